// File: compile.f
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_lsu.sv
source/rv_bus_arbiter.sv
source/rv_core.sv
tb/tb_clock.sv
tb/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# Build the rv_core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module rv_core_tb -f compile.f -o rv_core_sim \
  && ./obj_dir/rv_core_sim | tee /dev/stderr | grep -qx "Test OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: source/rv_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rv_bus_arbiter (
  input  wire                          clk,
  input  wire                          rst,
  input  wire rv_pkg::mem_req_t        fetch_req_i,
  input  wire                          fetch_req_valid_i,
  output logic                         fetch_req_ready_o,
  output logic                         fetch_rsp_valid_o,
  output logic [rv_pkg::XLEN-1:0]      fetch_rdata_o,
  input  wire rv_pkg::mem_req_t        lsu_req_i,
  input  wire                          lsu_req_valid_i,
  output logic                         lsu_req_ready_o,
  output logic                         lsu_rsp_valid_o,
  output logic [rv_pkg::XLEN-1:0]      lsu_rdata_o,
  output rv_pkg::mem_req_t             mem_req_o,
  output logic                         mem_req_valid_o,
  input  wire                          mem_req_ready_i,
  input  wire                          mem_rsp_valid_i,
  input  wire [rv_pkg::XLEN-1:0]       mem_rdata_i
);
  typedef enum logic [1:0] {OWN_NONE, OWN_FETCH, OWN_LSU} owner_e;

  owner_e owner;
  logic   free;

  assign free = (owner == OWN_NONE);

  // LSU has priority while the port is free
  assign mem_req_o         = lsu_req_valid_i ? lsu_req_i : fetch_req_i;
  assign mem_req_valid_o   = free && (lsu_req_valid_i || fetch_req_valid_i);
  assign lsu_req_ready_o   = free && mem_req_ready_i;
  assign fetch_req_ready_o = free && !lsu_req_valid_i && mem_req_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      owner <= OWN_NONE;
    end else if (free && mem_req_valid_o && mem_req_ready_i) begin
      owner <= lsu_req_valid_i ? OWN_LSU : OWN_FETCH;
    end else if (mem_rsp_valid_i) begin
      owner <= OWN_NONE;
    end
  end

  assign fetch_rsp_valid_o = mem_rsp_valid_i && (owner == OWN_FETCH);
  assign lsu_rsp_valid_o   = mem_rsp_valid_i && (owner == OWN_LSU);
  assign fetch_rdata_o     = mem_rdata_i;
  assign lsu_rdata_o       = mem_rdata_i;

endmodule

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  wire                          clk,
  input  wire                          rst,
  output rv_pkg::mem_req_t             mem_req_o,
  output logic                         mem_req_valid_o,
  input  wire                          mem_req_ready_i,
  input  wire                          mem_rsp_valid_i,
  input  wire [rv_pkg::XLEN-1:0]       mem_rdata_i,
  output logic                         halt_o
);
  // Stage loop
  rv_pkg::fetch_out_t      f_out;
  logic                    f_valid;
  logic                    d_ready;
  rv_pkg::decode_out_t     d_out;
  logic                    d_valid;
  logic                    e_ready;
  logic [rv_pkg::XLEN-1:0] next_pc;
  logic                    pc_load;

  // Register file
  logic [4:0]              rs1;
  logic [4:0]              rs2;
  logic [rv_pkg::XLEN-1:0] rdata1;
  logic [rv_pkg::XLEN-1:0] rdata2;
  logic                    rf_we;
  logic [4:0]              rf_rd;
  logic [rv_pkg::XLEN-1:0] rf_wdata;

  // Execute to LSU
  logic                    lsu_start;
  logic                    lsu_we;
  logic [rv_pkg::XLEN-1:0] lsu_addr;
  logic [rv_pkg::XLEN-1:0] lsu_wdata;
  logic                    lsu_done;
  logic [rv_pkg::XLEN-1:0] lsu_rdata;

  // Arbiter channels
  rv_pkg::mem_req_t        f_req;
  logic                    f_req_valid;
  logic                    f_req_ready;
  logic                    f_rsp_valid;
  logic [rv_pkg::XLEN-1:0] f_rdata;
  rv_pkg::mem_req_t        l_req;
  logic                    l_req_valid;
  logic                    l_req_ready;
  logic                    l_rsp_valid;
  logic [rv_pkg::XLEN-1:0] l_rdata;

  rv_fetch u_fetch (
    .clk(clk), .rst(rst),
    .next_pc_i(next_pc), .pc_load_i(pc_load), .halt_i(halt_o),
    .out_o(f_out), .valid_o(f_valid), .ready_i(d_ready),
    .req_o(f_req), .req_valid_o(f_req_valid), .req_ready_i(f_req_ready),
    .rsp_valid_i(f_rsp_valid), .rdata_i(f_rdata)
  );

  rv_decode u_decode (
    .clk(clk), .rst(rst),
    .in_i(f_out), .valid_i(f_valid), .ready_o(d_ready),
    .rs1_o(rs1), .rs2_o(rs2), .rdata1_i(rdata1), .rdata2_i(rdata2),
    .out_o(d_out), .valid_o(d_valid), .ready_i(e_ready)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst),
    .rs1_i(rs1), .rs2_i(rs2), .rdata1_o(rdata1), .rdata2_o(rdata2),
    .we_i(rf_we), .rd_i(rf_rd), .wdata_i(rf_wdata)
  );

  rv_execute u_execute (
    .clk(clk), .rst(rst),
    .in_i(d_out), .valid_i(d_valid), .ready_o(e_ready),
    .rf_we_o(rf_we), .rf_rd_o(rf_rd), .rf_wdata_o(rf_wdata),
    .next_pc_o(next_pc), .pc_load_o(pc_load), .halt_o(halt_o),
    .lsu_start_o(lsu_start), .lsu_we_o(lsu_we), .lsu_addr_o(lsu_addr),
    .lsu_wdata_o(lsu_wdata), .lsu_done_i(lsu_done), .lsu_rdata_i(lsu_rdata)
  );

  rv_lsu u_lsu (
    .clk(clk), .rst(rst),
    .start_i(lsu_start), .we_i(lsu_we), .addr_i(lsu_addr), .wdata_i(lsu_wdata),
    .done_o(lsu_done), .rdata_o(lsu_rdata),
    .req_o(l_req), .req_valid_o(l_req_valid), .req_ready_i(l_req_ready),
    .rsp_valid_i(l_rsp_valid), .rdata_i(l_rdata)
  );

  rv_bus_arbiter u_arbiter (
    .clk(clk), .rst(rst),
    .fetch_req_i(f_req), .fetch_req_valid_i(f_req_valid), .fetch_req_ready_o(f_req_ready),
    .fetch_rsp_valid_o(f_rsp_valid), .fetch_rdata_o(f_rdata),
    .lsu_req_i(l_req), .lsu_req_valid_i(l_req_valid), .lsu_req_ready_o(l_req_ready),
    .lsu_rsp_valid_o(l_rsp_valid), .lsu_rdata_o(l_rdata),
    .mem_req_o(mem_req_o), .mem_req_valid_o(mem_req_valid_o),
    .mem_req_ready_i(mem_req_ready_i), .mem_rsp_valid_i(mem_rsp_valid_i),
    .mem_rdata_i(mem_rdata_i)
  );

endmodule

`default_nettype wire

// File: source/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  wire                          clk,
  input  wire                          rst,
  input  wire rv_pkg::fetch_out_t      in_i,
  input  wire                          valid_i,
  output logic                         ready_o,
  output logic [4:0]                   rs1_o,
  output logic [4:0]                   rs2_o,
  input  wire [rv_pkg::XLEN-1:0]       rdata1_i,
  input  wire [rv_pkg::XLEN-1:0]       rdata2_i,
  output rv_pkg::decode_out_t          out_o,
  output logic                         valid_o,
  input  wire                          ready_i
);
  logic [31:0]             inst;
  rv_pkg::opcode_e         opcode;
  logic [rv_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
  rv_pkg::decode_out_t     dec;

  function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] funct3, input logic sub);
    case (funct3)
      3'b000:  alu_sel = sub ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b010:  alu_sel = rv_pkg::ALU_SLT;
      3'b100:  alu_sel = rv_pkg::ALU_XOR;
      3'b110:  alu_sel = rv_pkg::ALU_OR;
      3'b111:  alu_sel = rv_pkg::ALU_AND;
      default: alu_sel = rv_pkg::ALU_ADD;
    endcase
  endfunction

  assign inst   = in_i.inst;
  assign opcode = rv_pkg::opcode_e'(inst[6:0]);
  assign rs1_o  = inst[19:15];
  assign rs2_o  = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};

  always_comb begin
    dec        = '0;
    dec.pc     = in_i.pc;
    dec.rd     = inst[11:7];
    dec.opcode = opcode;
    dec.op1    = rdata1_i;
    dec.op2    = rdata2_i;
    dec.sdata  = rdata2_i;
    dec.alu_op = rv_pkg::ALU_ADD;
    case (opcode)
      rv_pkg::OP_LUI: begin
        dec.op2    = imm_u;
        dec.imm    = imm_u;
        dec.alu_op = rv_pkg::ALU_PASS_B;
        dec.rd_we  = 1'b1;
      end
      rv_pkg::OP_IMM: begin
        dec.op2    = imm_i;
        dec.imm    = imm_i;
        dec.alu_op = alu_sel(inst[14:12], 1'b0);
        dec.rd_we  = 1'b1;
      end
      rv_pkg::OP_REG: begin
        dec.alu_op = alu_sel(inst[14:12], inst[30]);
        dec.rd_we  = 1'b1;
      end
      rv_pkg::OP_LOAD: begin
        dec.op2   = imm_i;
        dec.imm   = imm_i;
        dec.rd_we = 1'b1;
      end
      rv_pkg::OP_STORE: begin
        dec.op2 = imm_s;
        dec.imm = imm_s;
      end
      // BEQ compares by subtraction, BNE by xor
      rv_pkg::OP_BRANCH: begin
        dec.imm    = imm_b;
        dec.alu_op = inst[12] ? rv_pkg::ALU_XOR : rv_pkg::ALU_SUB;
      end
      rv_pkg::OP_JAL: begin
        dec.op1   = in_i.pc;
        dec.op2   = imm_j;
        dec.imm   = imm_j;
        dec.rd_we = 1'b1;
      end
      default: dec.rd_we = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else if (valid_i && ready_o) begin
      valid_o <= 1'b1;
    end else if (ready_i) begin
      valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) out_o <= dec;
  end

  assign ready_o = !valid_o;

endmodule

`default_nettype wire

// File: source/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire                          clk,
  input  wire                          rst,
  input  wire rv_pkg::decode_out_t     in_i,
  input  wire                          valid_i,
  output logic                         ready_o,
  output logic                         rf_we_o,
  output logic [4:0]                   rf_rd_o,
  output logic [rv_pkg::XLEN-1:0]      rf_wdata_o,
  output logic [rv_pkg::XLEN-1:0]      next_pc_o,
  output logic                         pc_load_o,
  output logic                         halt_o,
  output logic                         lsu_start_o,
  output logic                         lsu_we_o,
  output logic [rv_pkg::XLEN-1:0]      lsu_addr_o,
  output logic [rv_pkg::XLEN-1:0]      lsu_wdata_o,
  input  wire                          lsu_done_i,
  input  wire [rv_pkg::XLEN-1:0]       lsu_rdata_i
);
  typedef enum logic [1:0] {E_IDLE, E_EXEC, E_MEM} state_e;

  state_e                  state;
  rv_pkg::decode_out_t     cur;
  logic [rv_pkg::XLEN-1:0] alu_res;
  logic [rv_pkg::XLEN-1:0] link;
  logic                    is_mem;
  logic                    taken;
  logic                    done_alu;
  logic                    done_mem;

  always_comb begin
    case (cur.alu_op)
      rv_pkg::ALU_SUB:    alu_res = cur.op1 - cur.op2;
      rv_pkg::ALU_AND:    alu_res = cur.op1 & cur.op2;
      rv_pkg::ALU_OR:     alu_res = cur.op1 | cur.op2;
      rv_pkg::ALU_XOR:    alu_res = cur.op1 ^ cur.op2;
      rv_pkg::ALU_SLT:    alu_res = {{(rv_pkg::XLEN-1){1'b0}}, $signed(cur.op1) < $signed(cur.op2)};
      rv_pkg::ALU_PASS_B: alu_res = cur.op2;
      default:            alu_res = cur.op1 + cur.op2;
    endcase
  end

  assign link   = cur.pc + 32'd4;
  assign is_mem = (cur.opcode == rv_pkg::OP_LOAD) || (cur.opcode == rv_pkg::OP_STORE);
  // BEQ on a zero difference, BNE on a nonzero xor
  assign taken  = (cur.opcode == rv_pkg::OP_BRANCH) &&
                  ((cur.alu_op == rv_pkg::ALU_SUB) ? (alu_res == '0) : (alu_res != '0));

  assign done_alu = (state == E_EXEC) && !is_mem;
  assign done_mem = (state == E_MEM) && lsu_done_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= E_IDLE;
      halt_o <= 1'b0;
    end else begin
      case (state)
        E_IDLE: if (valid_i) state <= E_EXEC;
        E_EXEC: begin
          state <= is_mem ? E_MEM : E_IDLE;
          if (cur.opcode == rv_pkg::OP_SYSTEM) halt_o <= 1'b1;
        end
        E_MEM:  if (lsu_done_i) state <= E_IDLE;
        default: state <= E_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) cur <= in_i;
  end

  assign ready_o = (state == E_IDLE);

  // Write-back and next PC
  assign rf_we_o    = (done_alu || done_mem) && cur.rd_we;
  assign rf_rd_o    = cur.rd;
  assign rf_wdata_o = (cur.opcode == rv_pkg::OP_JAL)  ? link :
                      (cur.opcode == rv_pkg::OP_LOAD) ? lsu_rdata_i : alu_res;
  assign next_pc_o  = (taken || cur.opcode == rv_pkg::OP_JAL) ? cur.pc + cur.imm : link;
  assign pc_load_o  = done_alu || done_mem;

  assign lsu_start_o = (state == E_EXEC) && is_mem;
  assign lsu_we_o    = (cur.opcode == rv_pkg::OP_STORE);
  assign lsu_addr_o  = alu_res;
  assign lsu_wdata_o = cur.sdata;

endmodule

`default_nettype wire

// File: source/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
  input  wire                          clk,
  input  wire                          rst,
  input  wire [rv_pkg::XLEN-1:0]       next_pc_i,
  input  wire                          pc_load_i,
  input  wire                          halt_i,
  output rv_pkg::fetch_out_t           out_o,
  output logic                         valid_o,
  input  wire                          ready_i,
  output rv_pkg::mem_req_t             req_o,
  output logic                         req_valid_o,
  input  wire                          req_ready_i,
  input  wire                          rsp_valid_i,
  input  wire [rv_pkg::XLEN-1:0]       rdata_i
);
  typedef enum logic [1:0] {F_IDLE, F_REQ, F_WAIT, F_HAND} state_e;

  state_e                  state;
  logic [rv_pkg::XLEN-1:0] pc;
  logic [31:0]             inst;
  // Set when the next fetch may start
  logic                    go;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= F_IDLE;
      pc    <= rv_pkg::PC_INIT;
      go    <= 1'b1;
    end else begin
      case (state)
        F_IDLE: if (go && !halt_i) begin
          state <= F_REQ;
          go    <= 1'b0;
        end
        F_REQ:  if (req_ready_i) state <= F_WAIT;
        F_WAIT: if (rsp_valid_i) state <= F_HAND;
        F_HAND: if (ready_i) state <= F_IDLE;
        default: state <= F_IDLE;
      endcase
      // Previous instruction retired
      if (pc_load_i) begin
        pc <= next_pc_i;
        go <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == F_WAIT && rsp_valid_i) inst <= rdata_i;
  end

  assign req_o       = '{addr: pc, wdata: '0, we: 1'b0};
  assign req_valid_o = (state == F_REQ);
  assign out_o       = '{pc: pc, inst: inst};
  assign valid_o     = (state == F_HAND);

endmodule

`default_nettype wire

// File: source/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          start_i,
  input  wire                          we_i,
  input  wire [rv_pkg::XLEN-1:0]       addr_i,
  input  wire [rv_pkg::XLEN-1:0]       wdata_i,
  output logic                         done_o,
  output logic [rv_pkg::XLEN-1:0]      rdata_o,
  output rv_pkg::mem_req_t             req_o,
  output logic                         req_valid_o,
  input  wire                          req_ready_i,
  input  wire                          rsp_valid_i,
  input  wire [rv_pkg::XLEN-1:0]       rdata_i
);
  typedef enum logic [1:0] {L_IDLE, L_REQ, L_WAIT} state_e;

  state_e state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= L_IDLE;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state)
        L_IDLE: if (start_i) state <= L_REQ;
        L_REQ:  if (req_ready_i) state <= L_WAIT;
        L_WAIT: if (rsp_valid_i) begin
          state  <= L_IDLE;
          done_o <= 1'b1;
        end
        default: state <= L_IDLE;
      endcase
    end
  end

  // Request held stable until accepted
  always_ff @(posedge clk) begin
    if (state == L_IDLE && start_i) req_o <= '{addr: addr_i, wdata: wdata_i, we: we_i};
    if (state == L_WAIT && rsp_valid_i) rdata_o <= rdata_i;
  end

  assign req_valid_o = (state == L_REQ);

endmodule

`default_nettype wire

// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] PC_INIT = 32'h0000_0000;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_PASS_B = 4'd6
  } alu_op_e;

  // Single-beat word request
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            we;
  } mem_req_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
  } fetch_out_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] sdata;
    logic [4:0]      rd;
    alu_op_e         alu_op;
    opcode_e         opcode;
    logic            rd_we;
  } decode_out_t;

endpackage

`default_nettype wire

// File: source/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire                          clk,
  input  wire                          rst,
  input  wire [4:0]                    rs1_i,
  input  wire [4:0]                    rs2_i,
  output logic [rv_pkg::XLEN-1:0]      rdata1_o,
  output logic [rv_pkg::XLEN-1:0]      rdata2_o,
  input  wire                          we_i,
  input  wire [4:0]                    rd_i,
  input  wire [rv_pkg::XLEN-1:0]       wdata_i
);
  logic [rv_pkg::XLEN-1:0] rf [32];

  // x0 clears on reset and is never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (we_i && rd_i != 5'd0) begin
      rf[rd_i] <= wdata_i;
    end
  end

  assign rdata1_o = rf[rs1_i];
  assign rdata2_o = rf[rs2_i];

endmodule

`default_nettype wire

// File: tb/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
  localparam int          NUM_TESTS   = 6;
  localparam int          HALT_LIMIT  = 380;
  localparam int          MEM_WORDS   = 1024;
  localparam logic [31:0] EBREAK_INST = 32'h0010_0073;
  localparam logic [6:0]  OPC_IMM     = 7'b0010011;
  localparam logic [6:0]  OPC_LOAD    = 7'b0000011;

  wire                     clk;
  wire                     por_rst;
  wire                     rst;
  logic                    test_rst;
  rv_pkg::mem_req_t        mem_req;
  logic                    mem_req_valid;
  logic                    mem_req_ready;
  logic                    mem_rsp_valid;
  logic [rv_pkg::XLEN-1:0] mem_rdata;
  logic                    halt;

  logic [31:0]             mem [MEM_WORDS];
  logic [31:0]             prog [$];
  logic [31:0]             wr_addr_q [$];
  logic [31:0]             wr_data_q [$];
  logic [31:0]             exp_addr_q [$];
  logic [31:0]             exp_data_q [$];
  rv_pkg::mem_req_t        pending;
  logic                    busy;
  int                      delay;
  int                      req_cycles;
  int                      errors;
  int                      checks;
  integer                  seed;

  assign rst = por_rst || test_rst;

  tb_clock clock_gen (.clk_o(clk), .rst_o(por_rst));

  rv_core dut_i (
    .clk(clk), .rst(rst),
    .mem_req_o(mem_req), .mem_req_valid_o(mem_req_valid), .mem_req_ready_i(mem_req_ready),
    .mem_rsp_valid_i(mem_rsp_valid), .mem_rdata_i(mem_rdata), .halt_o(halt)
  );

  // RV32I instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    r_type = {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    i_type = {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    s_type = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    b_type = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] lui_inst(input logic [4:0] rd, input logic [19:0] upper);
    lui_inst = {upper, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] off);
    jal_inst = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic check_word(input string name, input logic [rv_pkg::XLEN-1:0] expected,
                            input logic [rv_pkg::XLEN-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: store data expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_addr(input string name, input logic [rv_pkg::XLEN-1:0] expected,
                            input logic [rv_pkg::XLEN-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: store address expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_halt(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: halt expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic clear_program();
    prog.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
  endtask

  task automatic expect_write(input logic [31:0] addr, input logic [31:0] data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
  endtask

  task automatic preload(input logic [31:0] addr, input logic [31:0] data);
    mem[addr[11:2]] = data;
  endtask

  // Holds the core in reset while the memory is refilled
  task automatic start_test();
    @(posedge clk);
    #1;
    test_rst = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[10'(i)] = ~(32'(i) << 2);
    end
    foreach (prog[i]) begin
      mem[10'(i)] = prog[i];
    end
    wr_addr_q.delete();
    wr_data_q.delete();
    repeat (2) @(posedge clk);
  endtask

  task automatic run_program(input string name);
    int cycles;
    #1;
    test_rst = 1'b0;
    @(negedge clk);
    check_halt(name, 1'b0, halt);
    cycles = 0;
    while (!halt && cycles < HALT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      errors++;
      $display("%s: core did not halt within %0d cycles", name, HALT_LIMIT);
    end
  endtask

  task automatic verify_writes(input string name);
    if (wr_addr_q.size() != exp_addr_q.size()) begin
      errors++;
      $display("%s: expected %0d memory writes but saw %0d", name,
               exp_addr_q.size(), wr_addr_q.size());
    end else begin
      foreach (exp_addr_q[k]) begin
        check_addr(name, exp_addr_q[k], wr_addr_q[k]);
        check_word(name, exp_data_q[k], wr_data_q[k]);
      end
    end
  endtask

  task automatic alu_ops_test();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result [9];
    a = 32'd100;
    b = 32'hffff_fff9;
    result[0] = a;
    result[1] = a + b;
    result[2] = a - b;
    result[3] = a & b;
    result[4] = a | b;
    result[5] = a ^ b;
    result[6] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
    result[7] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    result[8] = 32'h1234_5000;
    clear_program();
    prog.push_back(i_type(OPC_IMM, 3'b000, 5'd1, 5'd0, 12'd100));
    prog.push_back(i_type(OPC_IMM, 3'b000, 5'd2, 5'd0, 12'hff9));
    prog.push_back(r_type(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
    prog.push_back(r_type(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd2));
    prog.push_back(r_type(7'b0000000, 3'b111, 5'd5, 5'd1, 5'd2));
    prog.push_back(r_type(7'b0000000, 3'b110, 5'd6, 5'd1, 5'd2));
    prog.push_back(r_type(7'b0000000, 3'b100, 5'd7, 5'd1, 5'd2));
    prog.push_back(r_type(7'b0000000, 3'b010, 5'd8, 5'd2, 5'd1));
    prog.push_back(r_type(7'b0000000, 3'b010, 5'd9, 5'd1, 5'd2));
    prog.push_back(lui_inst(5'd10, 20'h12345));
    // x1 first, then x3 to x10
    for (int k = 0; k < 9; k++) begin
      prog.push_back(s_type((k == 0) ? 5'd1 : 5'(k + 2), 5'd0, 12'(32'h200 + 4 * k)));
      expect_write(32'h200 + 32'(4 * k), result[k]);
    end
    prog.push_back(EBREAK_INST);
    start_test();
    run_program("alu_ops");
    verify_writes("alu_ops");
  endtask

  task automatic load_test();
    clear_program();
    prog.push_back(i_type(OPC_LOAD, 3'b010, 5'd1, 5'd0, 12'h300));
    prog.push_back(i_type(OPC_LOAD, 3'b010, 5'd2, 5'd0, 12'h304));
    prog.push_back(r_type(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
    prog.push_back(s_type(5'd3, 5'd0, 12'h308));
    prog.push_back(EBREAK_INST);
    expect_write(32'h308, 32'h1234_5678 + 32'h0000_1111);
    start_test();
    preload(32'h300, 32'h1234_5678);
    preload(32'h304, 32'h0000_1111);
    run_program("load");
    verify_writes("load");
  endtask

  task automatic branch_test();
    clear_program();
    prog.push_back(i_type(OPC_IMM, 3'b000, 5'd1, 5'd0, 12'd5));
    prog.push_back(i_type(OPC_IMM, 3'b000, 5'd2, 5'd0, 12'd5));
    prog.push_back(i_type(OPC_IMM, 3'b000, 5'd3, 5'd0, 12'd6));
    // Taken BEQ, not taken BEQ, taken BNE, not taken BNE
    prog.push_back(b_type(3'b000, 5'd1, 5'd2, 13'd8));
    prog.push_back(s_type(5'd1, 5'd0, 12'h400));
    prog.push_back(s_type(5'd1, 5'd0, 12'h404));
    prog.push_back(b_type(3'b000, 5'd1, 5'd3, 13'd8));
    prog.push_back(s_type(5'd1, 5'd0, 12'h408));
    prog.push_back(s_type(5'd1, 5'd0, 12'h40c));
    prog.push_back(b_type(3'b001, 5'd1, 5'd3, 13'd8));
    prog.push_back(s_type(5'd1, 5'd0, 12'h410));
    prog.push_back(s_type(5'd1, 5'd0, 12'h414));
    prog.push_back(b_type(3'b001, 5'd1, 5'd2, 13'd8));
    prog.push_back(s_type(5'd1, 5'd0, 12'h418));
    prog.push_back(s_type(5'd1, 5'd0, 12'h41c));
    prog.push_back(EBREAK_INST);
    expect_write(32'h404, 32'd5);
    expect_write(32'h408, 32'd5);
    expect_write(32'h40c, 32'd5);
    expect_write(32'h414, 32'd5);
    expect_write(32'h418, 32'd5);
    expect_write(32'h41c, 32'd5);
    start_test();
    run_program("branch");
    verify_writes("branch");
  endtask

  task automatic jal_test();
    clear_program();
    prog.push_back(i_type(OPC_IMM, 3'b000, 5'd2, 5'd0, 12'd7));
    // JAL at 0x4 jumps to 0x10
    prog.push_back(jal_inst(5'd1, 21'd12));
    prog.push_back(s_type(5'd2, 5'd0, 12'h500));
    prog.push_back(EBREAK_INST);
    prog.push_back(s_type(5'd1, 5'd0, 12'h504));
    prog.push_back(s_type(5'd2, 5'd0, 12'h508));
    prog.push_back(EBREAK_INST);
    expect_write(32'h504, 32'h4 + 32'h4);
    expect_write(32'h508, 32'd7);
    start_test();
    run_program("jal");
    verify_writes("jal");
  endtask

  task automatic x0_test();
    clear_program();
    prog.push_back(i_type(OPC_IMM, 3'b000, 5'd1, 5'd0, 12'd9));
    prog.push_back(i_type(OPC_IMM, 3'b000, 5'd0, 5'd0, 12'd123));
    prog.push_back(r_type(7'b0000000, 3'b000, 5'd0, 5'd1, 5'd1));
    prog.push_back(lui_inst(5'd0, 20'habcde));
    prog.push_back(s_type(5'd0, 5'd0, 12'h600));
    prog.push_back(s_type(5'd1, 5'd0, 12'h604));
    prog.push_back(EBREAK_INST);
    expect_write(32'h600, 32'd0);
    expect_write(32'h604, 32'd9);
    start_test();
    run_program("x0");
    verify_writes("x0");
  endtask

  task automatic halt_test();
    clear_program();
    prog.push_back(i_type(OPC_IMM, 3'b000, 5'd1, 5'd0, 12'd1));
    prog.push_back(s_type(5'd1, 5'd0, 12'h700));
    prog.push_back(EBREAK_INST);
    prog.push_back(s_type(5'd1, 5'd0, 12'h704));
    expect_write(32'h700, 32'd1);
    start_test();
    run_program("halt");
    @(posedge clk);
    #1;
    req_cycles = 0;
    repeat (40) @(negedge clk);
    check_halt("halt", 1'b1, halt);
    if (req_cycles != 0) begin
      errors++;
      $display("halt: %0d bus request cycles seen after EBREAK", req_cycles);
    end
    verify_writes("halt");
  endtask

  // Memory with random ready and a response 1 to 4 cycles after the transfer
  initial begin : memory_model
    logic             accept;
    logic             rsp_done;
    logic             in_reset;
    rv_pkg::mem_req_t req_now;
    forever begin
      @(negedge clk);
      accept   = mem_req_valid && mem_req_ready;
      rsp_done = mem_rsp_valid;
      in_reset = rst;
      req_now  = mem_req;
      if (mem_req_valid) req_cycles++;
      @(posedge clk);
      #1;
      mem_rsp_valid = 1'b0;
      mem_req_ready = (($random(seed) & 3) != 0);
      if (rsp_done || in_reset) busy = 1'b0;
      if (accept && !in_reset) begin
        busy    = 1'b1;
        pending = req_now;
        delay   = $random(seed) & 3;
        if (req_now.we) begin
          mem[req_now.addr[11:2]] = req_now.wdata;
          wr_addr_q.push_back(req_now.addr);
          wr_data_q.push_back(req_now.wdata);
        end
      end
      if (busy) begin
        if (delay == 0) begin
          mem_rsp_valid = 1'b1;
          mem_rdata     = mem[pending.addr[11:2]];
        end else begin
          delay--;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (NUM_TESTS * 400) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run stopped", NUM_TESTS * 400);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    seed          = 32'h97f2;
    test_rst      = 1'b1;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rdata     = '0;
    busy          = 1'b0;
    delay         = 0;
    req_cycles    = 0;
    errors        = 0;
    checks        = 0;
    alu_ops_test();
    load_test();
    branch_test();
    jal_test();
    x0_test();
    halt_test();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_o
);
  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Power-on reset over the first two rising edges
  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire
